// File: e_scale_defs.svh
`ifndef E_SCALE_DEFS_SVH
`define E_SCALE_DEFS_SVH

//////////////////////////////////////////////////
// row geometry
//////////////////////////////////////////////////

// 2 columns x 2 parallel pixels x 2 channels
`define LANES 8
// lanes owned by one channel in mode 1
`define HALF_LANES 4

//////////////////////////////////////////////////
// field widths
//////////////////////////////////////////////////

// biased pixel, 8x8 mode (16 bit + headroom)
`define PIX88_W 24
// biased pixel, 1x8 mode (8 bit + headroom)
`define PIX18_W 16
`define TAIL_W 16
`define RANK_W 8

// multiplier ports
`define MULT_A_W 24
`define MULT_B_W 16
`define MULT_P_W 40

// product fields seen by the quantizer, msb acts as relu sign
`define PROD88_W 40
`define PROD18_W 32

`define QPIX_W 8

`endif

// File: e_scale_pkg.sv
`default_nettype none

`include "e_scale_defs.svh"

package e_scale_pkg;

  //////////////////////////////////////////////////
  // per-channel scale set, given one cycle ahead
  //////////////////////////////////////////////////

  // 48 bits, channel 1 fields on top
  typedef struct packed {
    logic [`TAIL_W-1:0] tail1;
    logic [`TAIL_W-1:0] tail0;
    logic [`RANK_W-1:0] rank1;
    logic [`RANK_W-1:0] rank0;
  } scale_set_t;

  //////////////////////////////////////////////////
  // datapath rows
  //////////////////////////////////////////////////

  // 128 bit raw row
  // mode 1: ch0 = lanes 0..3, ch1 = lanes 4..7, 16 bit each
  // mode 0: same bits read as four 24 bit pixels from bit 0 up
  typedef struct packed {
    logic [`HALF_LANES-1:0][`PIX18_W-1:0] ch1;
    logic [`HALF_LANES-1:0][`PIX18_W-1:0] ch0;
  } bias_row_t;

  // operand rows for the multiplier array, 320 bits
  typedef struct packed {
    logic [`LANES-1:0][`MULT_A_W-1:0] a;
    logic [`LANES-1:0][`MULT_B_W-1:0] b;
  } mult_operand_t;

  // registered products, one per lane
  typedef struct packed {
    logic [`LANES-1:0][`MULT_P_W-1:0] p;
  } product_row_t;

  // 8 bit quantized pixels
  typedef struct packed {
    logic [`LANES-1:0][`QPIX_W-1:0] q;
  } quant_row_t;

endpackage

`default_nettype wire

// File: e_scale.sv
`timescale 1ns/10ps
`default_nettype none

`include "e_scale_defs.svh"

module e_scale (
  input  wire                          clk,
  input  wire                          e_tail_reset,
  // cycle -1
  input  wire e_scale_pkg::scale_set_t scale_set,
  // cycle 0
  input  wire                          mode,
  input  wire                          row_valid,
  input  wire e_scale_pkg::bias_row_t  bias_row,
  output e_scale_pkg::mult_operand_t   mult_operand,
  // cycle 1
  input  wire e_scale_pkg::product_row_t product_row,
  output e_scale_pkg::quant_row_t      quantified_row,
  output logic                         quantified_valid
);

  // index 0 is channel 0 and index 1 is channel 1
  logic [1:0][`TAIL_W-1:0] tail_q;
  logic [1:0][`RANK_W-1:0] rank_d1;
  logic [1:0][`RANK_W-1:0] rank_d2;
  logic                    mode_q;
  logic                    valid_q;

  // flat view of the row for the 24 bit stride
  logic [$bits(e_scale_pkg::bias_row_t)-1:0] row_flat;

  logic [`LANES-1:0][`MULT_A_W-1:0] op_a;
  logic [`LANES-1:0][`MULT_B_W-1:0] op_b;
  logic [`LANES-1:0][`QPIX_W-1:0]   q_lane;

  //////////////////////////////////////////////////
  // scale set delay line
  //////////////////////////////////////////////////

  // tail one stage, lines up with the cycle 0 operands
  // rank two stages, lines up with the cycle 1 products
  always_ff @(posedge clk)
  begin
    if (e_tail_reset)
    begin
      tail_q  <= '0;
      rank_d1 <= '0;
      rank_d2 <= '0;
      mode_q  <= 1'b0;
      valid_q <= 1'b0;
    end
    else
    begin
      tail_q  <= {scale_set.tail1, scale_set.tail0};
      rank_d1 <= {scale_set.rank1, scale_set.rank0};
      rank_d2 <= rank_d1;
      // mode and valid follow the row into the product cycle
      mode_q  <= mode;
      valid_q <= row_valid;
    end
  end

  //////////////////////////////////////////////////
  // operand formatting in cycle 0
  //////////////////////////////////////////////////

  assign row_flat = bias_row;

  for (genvar i = 0; i < `HALF_LANES; i++)
  begin : g_operand
    // low half takes a 24 bit pixel in mode 0 or a zero-extended ch0 pixel in mode 1
    assign op_a[i] = mode ? {{(`MULT_A_W-`PIX18_W){1'b0}}, bias_row.ch0[i]}
                          : row_flat[i*`PIX88_W +: `PIX88_W];
    // high half only carries channel 1
    assign op_a[i+`HALF_LANES] = mode ? {{(`MULT_A_W-`PIX18_W){1'b0}}, bias_row.ch1[i]}
                                      : '0;
    assign op_b[i]             = tail_q[0];
    assign op_b[i+`HALF_LANES] = mode ? tail_q[1] : '0;
  end

  assign mult_operand = '{a: op_a, b: op_b};

  //////////////////////////////////////////////////
  // relu and rank shift in cycle 1
  //////////////////////////////////////////////////

  for (genvar i = 0; i < `HALF_LANES; i++)
  begin : g_quant_lo
    logic [`PROD88_W-1:0] field88;
    logic [`PROD18_W-1:0] field18;
    logic [`PROD88_W-1:0] shift88;
    logic [`PROD18_W-1:0] shift18;

    assign field88 = product_row.p[i][`PROD88_W-1:0];
    assign field18 = product_row.p[i][`PROD18_W-1:0];
    // channel 0 rank serves both modes here
    assign shift88 = field88 >> rank_d2[0];
    assign shift18 = field18 >> rank_d2[0];
    // negative field clamps to 0 and otherwise keeps the low byte
    assign q_lane[i] = !mode_q ? (field88[`PROD88_W-1] ? '0 : shift88[`QPIX_W-1:0])
                               : (field18[`PROD18_W-1] ? '0 : shift18[`QPIX_W-1:0]);
  end

  for (genvar i = `HALF_LANES; i < `LANES; i++)
  begin : g_quant_hi
    logic [`PROD18_W-1:0] field18;
    logic [`PROD18_W-1:0] shift18;

    assign field18 = product_row.p[i][`PROD18_W-1:0];
    assign shift18 = field18 >> rank_d2[1];
    // idle in mode 0
    assign q_lane[i] = (mode_q && !field18[`PROD18_W-1]) ? shift18[`QPIX_W-1:0] : '0;
  end

  assign quantified_row   = '{q: q_lane};
  assign quantified_valid = valid_q;

  //////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////

  // a mode 0 row leaves the high half idle so its products come back zero
  a_mode0_high_idle : assert property (
    @(posedge clk) disable iff (e_tail_reset)
    (row_valid && !mode) |=> (product_row.p[`LANES-1:`HALF_LANES] == '0)
  );

endmodule

`default_nettype wire

// File: scale_mult_array.sv
`timescale 1ns/10ps
`default_nettype none

`include "e_scale_defs.svh"

module scale_mult_array (
  input  wire                             clk,
  input  wire                             e_tail_reset,
  input  wire e_scale_pkg::mult_operand_t mult_operand,
  output e_scale_pkg::product_row_t       product_row
);

  logic [`LANES-1:0][`MULT_P_W-1:0] prod_d;

  //////////////////////////////////////////////////
  // unsigned multipliers, one per lane
  //////////////////////////////////////////////////

  // 24 x 16 unsigned gives at most 40 bits, full width kept
  for (genvar i = 0; i < `LANES; i++)
  begin : g_mult
    assign prod_d[i] = mult_operand.a[i] * mult_operand.b[i];
  end

  //////////////////////////////////////////////////
  // product register, single cycle latency
  //////////////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (e_tail_reset)
    begin
      product_row <= '0;
    end
    else
    begin
      product_row.p <= prod_d;
    end
  end

  // narrow operand A must leave the guard above the mode 1 field clear
  for (genvar i = 0; i < `LANES; i++)
  begin : g_chk
    a_guard_clear : assert property (
      @(posedge clk) disable iff (e_tail_reset)
      (mult_operand.a[i][`MULT_A_W-1:`PIX18_W] == '0) |=>
        (product_row.p[i][`MULT_P_W-1:`PROD18_W] == '0)
    );
  end

endmodule

`default_nettype wire

// File: requant_top.sv
`timescale 1ns/10ps
`default_nettype none

module requant_top (
  input  wire                          clk,
  input  wire                          e_tail_reset,
  // scale set leads its row by one cycle
  input  wire e_scale_pkg::scale_set_t scale_set,
  input  wire                          mode,
  input  wire                          row_valid,
  input  wire e_scale_pkg::bias_row_t  bias_row,
  // one cycle after the row
  output e_scale_pkg::quant_row_t      quantified_row,
  output logic                         quantified_valid
);

  //////////////////////////////////////////////////
  // operand and product buses
  //////////////////////////////////////////////////

  e_scale_pkg::mult_operand_t mult_operand;
  e_scale_pkg::product_row_t  product_row;

  // formatting in front, quantizing behind the multipliers
  e_scale e_scale_inst (
    .clk              (clk),
    .e_tail_reset     (e_tail_reset),
    .scale_set        (scale_set),
    .mode             (mode),
    .row_valid        (row_valid),
    .bias_row         (bias_row),
    .mult_operand     (mult_operand),
    .product_row      (product_row),
    .quantified_row   (quantified_row),
    .quantified_valid (quantified_valid)
  );

  // product lands in the cycle after its operands
  scale_mult_array scale_mult_array_inst (
    .clk          (clk),
    .e_tail_reset (e_tail_reset),
    .mult_operand (mult_operand),
    .product_row  (product_row)
  );

endmodule

`default_nettype wire

// File: tb_clk_gen.sv
`timescale 1ns/10ps
`default_nettype none

// free-running clock for the testbench
module tb_clk_gen #(
  parameter real period_ns = 20.0
) (
  output logic clk
);

  initial
  begin
    clk = 1'b0;
  end

  // toggle every half period
  always
  begin
    #(period_ns / 2.0) clk = ~clk;
  end

endmodule

`default_nettype wire

// File: tb_requant.sv
`timescale 1ns/10ps
`default_nettype none

module tb_requant;

  localparam int max_lines    = 64;
  localparam int reset_cycles = 10;
  localparam int settle_ns    = 2;

  logic                       clk;
  logic                       e_tail_reset;
  e_scale_pkg::scale_set_t    scale_set;
  logic                       mode;
  logic                       row_valid;
  e_scale_pkg::bias_row_t     bias_row;
  e_scale_pkg::quant_row_t    quantified_row;
  logic                       quantified_valid;

  // one word per row holding test, scale set, mode, valid, bias row and expected row
  logic [255:0] pattern_mem [0:max_lines-1];
  int           n_lines;
  int           cycle_count = 0;
  int           cycle_limit = 0;
  integer       seed = 25332;

  // per-test and overall bookkeeping
  int cur_test;
  int test_checks;
  int test_errors;
  int tests_run;
  int tests_failed;
  int total_checks;
  int total_errors;

  tb_clk_gen clk_gen_inst (
    .clk (clk)
  );

  requant_top requant_top_inst (
    .clk              (clk),
    .e_tail_reset     (e_tail_reset),
    .scale_set        (scale_set),
    .mode             (mode),
    .row_valid        (row_valid),
    .bias_row         (bias_row),
    .quantified_row   (quantified_row),
    .quantified_valid (quantified_valid)
  );

  //////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////

  function automatic string test_name(input int num);
    case (num)
      1: return "reset and idle";
      2: return "mode 0 rows";
      3: return "mode 1 rows";
      4: return "relu clamp";
      5: return "back-to-back rows";
      default: return "unnamed";
    endcase
  endfunction

  task automatic check_value(input string sig, input logic [63:0] exp_val,
                             input logic [63:0] act_val);
    test_checks++;
    total_checks++;
    assert (act_val === exp_val)
    else
    begin
      $display("Fail at %0t: %s expected %h, got %h", $time, sig, exp_val, act_val);
      test_errors++;
      total_errors++;
    end
  endtask

  // one summary line for the test that just ended
  task automatic close_test();
    tests_run++;
    if (test_errors != 0)
      tests_failed++;
    $display("test %0d %s: %0d checks, %0d errors, %s", cur_test, test_name(cur_test),
             test_checks, test_errors, (test_errors == 0) ? "passed" : "failed");
    test_checks = 0;
    test_errors = 0;
  endtask

  // result of a row is visible one rising edge after it was driven
  task automatic check_line(input logic [255:0] pat);
    if (int'(pat[255:248]) != cur_test)
    begin
      close_test();
      cur_test = int'(pat[255:248]);
    end
    check_value("quantified_valid", 64'(pat[192]), 64'(quantified_valid));
    check_value("quantified_row", pat[63:0], quantified_row);
  endtask

  task automatic drive_row(input logic [255:0] pat);
    mode      = pat[196];
    row_valid = pat[192];
    bias_row  = pat[191:64];
  endtask

  //////////////////////////////////////////////////
  // stimulus and checking
  //////////////////////////////////////////////////

  initial
  begin : run_tests
    int k;
    e_tail_reset = 1'b1;
    scale_set    = '0;
    mode         = 1'b0;
    row_valid    = 1'b0;
    bias_row     = '0;
    cur_test     = 1;
    test_checks  = 0;
    test_errors  = 0;
    tests_run    = 0;
    tests_failed = 0;
    total_checks = 0;
    total_errors = 0;
    n_lines      = 0;

    // unused entries stay zero so test number 0 ends the list
    for (k = 0; k < max_lines; k++)
      pattern_mem[k] = '0;
    $readmemh("requant_patterns.txt", pattern_mem);
    while (n_lines < max_lines && pattern_mem[n_lines][255:248] != 8'h00)
      n_lines++;
    cycle_limit = n_lines + reset_cycles + 20;

    repeat (reset_cycles) @(posedge clk);
    @(negedge clk);
    // reset is still held here so the output stage must be clear
    check_value("quantified_valid", 64'b0, 64'(quantified_valid));
    check_value("quantified_row", 64'b0, quantified_row);
    e_tail_reset = 1'b0;

    if (n_lines == 0)
    begin
      $display("no pattern lines could be read from requant_patterns.txt");
      total_errors++;
    end
    else
    begin
      // scale set leads its row by one cycle
      scale_set = pattern_mem[0][247:200];
      for (k = 0; k < n_lines; k++)
      begin
        @(negedge clk);
        drive_row(pattern_mem[k]);
        scale_set = (k + 1 < n_lines) ? pattern_mem[k+1][247:200] : 48'h0;
        // previous row is checked while the next one already sits on the inputs
        #(settle_ns);
        if (k > 0)
          check_line(pattern_mem[k-1]);
      end
      // idle row with the other mode behind the last one
      @(negedge clk);
      mode      = ~pattern_mem[n_lines-1][196];
      row_valid = 1'b0;
      bias_row  = '0;
      #(settle_ns);
      check_line(pattern_mem[n_lines-1]);
    end

    close_test();
    $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
             tests_run, tests_failed, total_checks, total_errors);
    if (total_errors == 0)
    begin
      $display("** PASS **");
    end
    else
    begin
      $display("** FAIL **");
    end
    $finish;
  end

  //////////////////////////////////////////////////
  // timeout
  //////////////////////////////////////////////////

  // limit is known once the pattern count is in
  always @(posedge clk)
  begin
    cycle_count++;
    if (cycle_limit > 0 && cycle_count > cycle_limit)
    begin
      $display("run did not finish within %0d cycles", cycle_limit);
      $display("** FAIL **");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: requant_patterns.txt
// test _ tail1 _ tail0 _ rank1 _ rank0 _ mode _ valid _ bias row (128b) _ expected row (64b)
// scale set belongs to the row on the same line, the testbench drives it one cycle earlier

// test 1: idle rows after reset
01_0000_0000_00_00_0_0_00000000000000000000000000000000_0000000000000000
01_0000_0000_00_00_0_0_00000000000000000000000000000000_0000000000000000

// test 2: mode 0, four 24 bit pixels in the low 96 bits
02_FFFF_0003_07_04_0_1_000000000000A57FFFFF001234000100_000000001EFF6930
02_0000_0100_00_0C_0_1_00000000000000000ABCFFFFFF123456_0000000000ABFF45

// test 3: mode 1, channel 1 in the high half
03_0200_0010_08_03_1_1_0A0A00FF1234000100557FFF01230001_14FE6802AAFE4602
03_0001_0002_00_00_1_1_0000FFFF123400AB00037FFF00800010_00FF34AB06FE0020

// test 4: sign bit of the product field clamps to zero
04_0000_FFFF_00_20_0_1_00000000400000810000800000FFFFFF_000000003F007F00
04_C000_FFFF_10_18_1_1_AAAAAAAB1234FFFF100080018000FFFF_FF00A7000F007F00

// test 5: consecutive rows, scale set and mode change every cycle
05_0001_0001_00_00_1_1_0A0A00FF1234000100557FFF01230001_0AFF340155FF2301
05_1234_0001_05_08_0_1_000000000000A57FFFFF001234000100_0000000000FF1201
05_0003_0004_00_01_1_1_0000FFFF123400AB00037FFF00800010_00FD9C0106FE0020
05_0000_0000_00_00_0_0_00000000000000000000000000000000_0000000000000000
05_0000_0002_00_01_0_1_00000000000000000ABCFFFFFF123456_0000000000BCFF56

// File: tb.f
+incdir+.
e_scale_pkg.sv
e_scale.sv
scale_mult_array.sv
requant_top.sv
tb_clk_gen.sv
tb_requant.sv
